/* Bender.yml */
package:
  name: axi_burst_slave

sources:
  - source/axi_slave_pkg.sv
  - source/axi_txn_arbiter.sv
  - source/axi_addr_gen.sv
  - source/axi_write_ctrl.sv
  - source/axi_read_ctrl.sv
  - source/beat_memory.sv
  - source/axi_burst_slave.sv
  - target: simulation
    files:
      - bench/axi_burst_slave_asserts.sv
      - bench/tb_axi_burst_slave.sv

/* bench/axi_burst_slave_asserts.sv */
`timescale 1ns/10ps

module axi_burst_slave_asserts (
  input logic i_s_axi_aclk,
  input logic i_s_axi_aresetn,
  input logic i_awvalid,
  input logic i_awready,
  input logic i_wvalid,
  input logic i_wready,
  input logic i_bvalid,
  input logic i_bready,
  input logic i_arvalid,
  input logic i_arready,
  input logic i_rvalid,
  input logic i_rready,
  input logic i_rlast
);

  int assert_fails = 0;

  // VALID may not drop before its READY
  property valid_held(v, r);
    @(posedge i_s_axi_aclk) disable iff (!i_s_axi_aresetn) (v && !r) |=> v;
  endproperty

  aw_held: assert property (valid_held(i_awvalid, i_awready)) else begin
    assert_fails++;
    $error("AWVALID dropped before AWREADY");
  end

  w_held: assert property (valid_held(i_wvalid, i_wready)) else begin
    assert_fails++;
    $error("WVALID dropped before WREADY");
  end

  b_held: assert property (valid_held(i_bvalid, i_bready)) else begin
    assert_fails++;
    $error("BVALID dropped before BREADY");
  end

  ar_held: assert property (valid_held(i_arvalid, i_arready)) else begin
    assert_fails++;
    $error("ARVALID dropped before ARREADY");
  end

  r_held: assert property (valid_held(i_rvalid, i_rready)) else begin
    assert_fails++;
    $error("RVALID dropped before RREADY");
  end

  // One transaction at a time
  one_ready: assert property (@(posedge i_s_axi_aclk) disable iff (!i_s_axi_aresetn)
                              !(i_awready && i_arready)) else begin
    assert_fails++;
    $error("AWREADY and ARREADY high together");
  end

  b_reset: assert property (@(posedge i_s_axi_aclk) !i_s_axi_aresetn |=> !i_bvalid) else begin
    assert_fails++;
    $error("BVALID high after reset");
  end

  rlast_valid: assert property (@(posedge i_s_axi_aclk) disable iff (!i_s_axi_aresetn)
                                i_rlast |-> i_rvalid) else begin
    assert_fails++;
    $error("RLAST high without RVALID");
  end

endmodule

bind axi_burst_slave axi_burst_slave_asserts u_asserts (
  .i_s_axi_aclk   (i_s_axi_aclk),
  .i_s_axi_aresetn(i_s_axi_aresetn),
  .i_awvalid      (i_s_axi_awvalid),
  .i_awready      (o_s_axi_awready),
  .i_wvalid       (i_s_axi_wvalid),
  .i_wready       (o_s_axi_wready),
  .i_bvalid       (o_s_axi_bvalid),
  .i_bready       (i_s_axi_bready),
  .i_arvalid      (i_s_axi_arvalid),
  .i_arready      (o_s_axi_arready),
  .i_rvalid       (o_s_axi_rvalid),
  .i_rready       (i_s_axi_rready),
  .i_rlast        (o_s_axi_rlast)
);

/* bench/tb_axi_burst_slave.sv */
`timescale 1ns/10ps

module tb_axi_burst_slave;

  logic                  aclk;
  logic                  aresetn;
  axi_slave_pkg::addr_t  awaddr;
  axi_slave_pkg::len_t   awlen;
  axi_slave_pkg::burst_t awburst;
  axi_slave_pkg::id_t    awid;
  logic                  awvalid;
  logic                  awready;
  axi_slave_pkg::data_t  wdata;
  axi_slave_pkg::strb_t  wstrb;
  logic                  wlast;
  logic                  wvalid;
  logic                  wready;
  logic                  bready;
  logic                  bvalid;
  axi_slave_pkg::id_t    bid;
  logic [1:0]            bresp;
  axi_slave_pkg::addr_t  araddr;
  axi_slave_pkg::len_t   arlen;
  axi_slave_pkg::burst_t arburst;
  axi_slave_pkg::id_t    arid;
  logic                  arvalid;
  logic                  arready;
  logic                  rready;
  logic                  rvalid;
  axi_slave_pkg::data_t  rdata;
  axi_slave_pkg::id_t    rid;
  logic [1:0]            rresp;
  logic                  rlast;

  logic [31:0] lfsr_state = 32'd85889;
  logic        gaps_on;
  int          mismatch_cnt;
  int          timeout_cnt;

  // Byte-wide model of the slave memory
  logic [7:0] ref_mem [0:(1 << axi_slave_pkg::ADDR_W)-1];

  // Burst state tracked from the handshakes
  axi_slave_pkg::addr_t  wr_addr_m;
  axi_slave_pkg::len_t   wr_len_m;
  axi_slave_pkg::burst_t wr_burst_m;
  axi_slave_pkg::id_t    wr_id_m;
  axi_slave_pkg::addr_t  rd_addr_m;
  axi_slave_pkg::len_t   rd_len_m;
  axi_slave_pkg::burst_t rd_burst_m;
  axi_slave_pkg::id_t    rd_id_m;
  int                    rd_beat;
  logic                  rd_open;
  int                    cyc;
  int                    b_cyc;
  int                    ar_cyc;

  axi_burst_slave dut (
    .i_s_axi_aclk   (aclk),
    .i_s_axi_aresetn(aresetn),
    .i_s_axi_awaddr (awaddr),
    .i_s_axi_awlen  (awlen),
    .i_s_axi_awburst(awburst),
    .i_s_axi_awid   (awid),
    .i_s_axi_awvalid(awvalid),
    .o_s_axi_awready(awready),
    .i_s_axi_wdata  (wdata),
    .i_s_axi_wstrb  (wstrb),
    .i_s_axi_wlast  (wlast),
    .i_s_axi_wvalid (wvalid),
    .o_s_axi_wready (wready),
    .i_s_axi_bready (bready),
    .o_s_axi_bvalid (bvalid),
    .o_s_axi_bid    (bid),
    .o_s_axi_bresp  (bresp),
    .i_s_axi_araddr (araddr),
    .i_s_axi_arlen  (arlen),
    .i_s_axi_arburst(arburst),
    .i_s_axi_arid   (arid),
    .i_s_axi_arvalid(arvalid),
    .o_s_axi_arready(arready),
    .i_s_axi_rready (rready),
    .o_s_axi_rvalid (rvalid),
    .o_s_axi_rdata  (rdata),
    .o_s_axi_rid    (rid),
    .o_s_axi_rresp  (rresp),
    .o_s_axi_rlast  (rlast)
  );

  always #2 aclk = ~aclk;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v          = {v[62:0], fb};
    end
    return v;
  endfunction

  // Address of the following beat, 8 bytes per beat
  function automatic axi_slave_pkg::addr_t next_addr(input axi_slave_pkg::addr_t a,
                                                     input axi_slave_pkg::len_t len,
                                                     input axi_slave_pkg::burst_t burst);
    int aligned;
    int size;
    int base;
    aligned = int'(a) / 8 * 8;
    size    = (int'(len) + 1) * 8;
    base    = int'(a) / size * size;
    case (burst)
      axi_slave_pkg::BURST_FIXED: return a;
      axi_slave_pkg::BURST_WRAP:  return axi_slave_pkg::addr_t'(base + (aligned + 8 - base) % size);
      default:                    return axi_slave_pkg::addr_t'(aligned + 8);
    endcase
  endfunction

  function automatic axi_slave_pkg::data_t model_word(input axi_slave_pkg::addr_t a);
    axi_slave_pkg::data_t w;
    int                   base;
    base = int'(a) / 8 * 8;
    for (int b = 0; b < 8; b++) begin
      w[b*8 +: 8] = ref_mem[base + b];
    end
    return w;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic logic chan_hit(input int ch);
    case (ch)
      0:       return awready;
      1:       return wready;
      2:       return arready;
      3:       return rvalid & rready & rlast;
      default: return bvalid & bready;
    endcase
  endfunction

  // Wait on a rising edge where the selected condition holds
  task automatic wait_for(input int ch, input string what);
    int   n;
    logic hit;
    n   = 0;
    hit = 1'b0;
    while (!hit && n < 300) begin
      @(posedge aclk);
      hit = chan_hit(ch);
      n++;
    end
    if (!hit) begin
      timeout_cnt++;
      $display("Timeout: no %s within 300 cycles at %0t", what, $time);
    end
  endtask

  task automatic write_burst(input axi_slave_pkg::addr_t addr, input axi_slave_pkg::len_t len,
                             input axi_slave_pkg::burst_t burst, input axi_slave_pkg::id_t id,
                             input logic rand_strb, input logic gaps);
    @(negedge aclk);
    awaddr  = addr;
    awlen   = len;
    awburst = burst;
    awid    = id;
    awvalid = 1'b1;
    wait_for(0, "AWREADY");
    @(negedge aclk);
    awvalid = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      if (gaps && rand_bits(1) != 0) begin
        @(negedge aclk);
      end
      wdata  = rand_bits(64);
      wstrb  = rand_strb ? axi_slave_pkg::strb_t'(rand_bits(8)) : 8'hff;
      wlast  = (i == int'(len));
      wvalid = 1'b1;
      wait_for(1, "WREADY");
      @(negedge aclk);
      wvalid = 1'b0;
      wlast  = 1'b0;
    end
    wait_for(4, "B handshake");
  endtask

  task automatic read_burst(input axi_slave_pkg::addr_t addr, input axi_slave_pkg::len_t len,
                            input axi_slave_pkg::burst_t burst, input axi_slave_pkg::id_t id);
    @(negedge aclk);
    araddr  = addr;
    arlen   = len;
    arburst = burst;
    arid    = id;
    arvalid = 1'b1;
    wait_for(2, "ARREADY");
    @(negedge aclk);
    arvalid = 1'b0;
    wait_for(3, "last R beat");
  endtask

  // RREADY and BREADY stall at random while gaps are on
  always @(negedge aclk) begin
    if (gaps_on) begin
      rready = rand_bits(1) != 0;
      bready = rand_bits(1) != 0;
    end else begin
      rready = 1'b1;
      bready = 1'b1;
    end
  end

  // Model update and response compare on every handshake
  always @(posedge aclk) begin
    int base;
    cyc++;
    if (aresetn) begin
      if (awvalid && awready) begin
        wr_addr_m  = awaddr;
        wr_len_m   = awlen;
        wr_burst_m = awburst;
        wr_id_m    = awid;
      end
      if (wvalid && wready) begin
        base = int'(wr_addr_m) / 8 * 8;
        for (int b = 0; b < 8; b++) begin
          if (wstrb[b]) begin
            ref_mem[base + b] = wdata[b*8 +: 8];
          end
        end
        wr_addr_m = next_addr(wr_addr_m, wr_len_m, wr_burst_m);
      end
      if (bvalid && bready) begin
        compare_value("BID", bid, wr_id_m);
        compare_value("BRESP", bresp, 2'b00);
        b_cyc = cyc;
      end
      if (arvalid && arready) begin
        rd_addr_m  = araddr;
        rd_len_m   = arlen;
        rd_burst_m = arburst;
        rd_id_m    = arid;
        rd_beat    = 0;
        rd_open    = 1'b1;
        ar_cyc     = cyc;
      end
      if (rvalid && rready) begin
        if (!rd_open) begin
          mismatch_cnt++;
          $display("R beat arrived with no read burst open at %0t", $time);
        end else begin
          compare_value("RDATA", rdata, model_word(rd_addr_m));
          compare_value("RLAST", rlast, rd_beat == int'(rd_len_m));
          compare_value("RID", rid, rd_id_m);
          compare_value("RRESP", rresp, 2'b00);
          if (rd_beat == int'(rd_len_m)) begin
            rd_open = 1'b0;
          end
          rd_addr_m = next_addr(rd_addr_m, rd_len_m, rd_burst_m);
          rd_beat++;
        end
      end
    end
  end

  initial begin
    axi_slave_pkg::addr_t addr;
    axi_slave_pkg::len_t  len;
    int                   total;
    aclk         = 1'b0;
    aresetn      = 1'b0;
    awaddr       = '0;
    awlen        = '0;
    awburst      = axi_slave_pkg::BURST_INCR;
    awid         = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wlast        = 1'b0;
    wvalid       = 1'b0;
    bready       = 1'b1;
    araddr       = '0;
    arlen        = '0;
    arburst      = axi_slave_pkg::BURST_INCR;
    arid         = '0;
    arvalid      = 1'b0;
    rready       = 1'b1;
    gaps_on      = 1'b0;
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    rd_open      = 1'b0;
    cyc          = 0;
    b_cyc        = 0;
    ar_cyc       = 0;
    repeat (10) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;

    // Fill every word so the model starts fully known
    write_burst(10'h000, 8'd127, axi_slave_pkg::BURST_INCR, 4'h0, 1'b0, 1'b0);

    write_burst(10'h040, 8'd7, axi_slave_pkg::BURST_INCR, 4'h1, 1'b0, 1'b0);
    read_burst(10'h040, 8'd7, axi_slave_pkg::BURST_INCR, 4'h2);

    // Starts mid-block, wraps back to 0x100
    write_burst(10'h110, 8'd3, axi_slave_pkg::BURST_WRAP, 4'h3, 1'b0, 1'b0);
    read_burst(10'h100, 8'd3, axi_slave_pkg::BURST_INCR, 4'h4);

    write_burst(10'h200, 8'd3, axi_slave_pkg::BURST_FIXED, 4'h5, 1'b1, 1'b0);
    read_burst(10'h200, 8'd2, axi_slave_pkg::BURST_FIXED, 4'h6);
    read_burst(10'h1f8, 8'd2, axi_slave_pkg::BURST_INCR, 4'h7);

    repeat (3) begin
      addr = axi_slave_pkg::addr_t'(rand_bits(7) << 3);
      write_burst(addr, 8'd3, axi_slave_pkg::BURST_INCR, 4'h8, 1'b1, 1'b0);
      read_burst(addr, 8'd3, axi_slave_pkg::BURST_INCR, 4'h9);
    end

    gaps_on = 1'b1;
    for (int t = 0; t < 4; t++) begin
      addr = axi_slave_pkg::addr_t'(rand_bits(7) << 3);
      len  = axi_slave_pkg::len_t'(rand_bits(3));
      write_burst(addr, len, axi_slave_pkg::BURST_INCR, axi_slave_pkg::id_t'(t), 1'b1, 1'b1);
      read_burst(addr, len, axi_slave_pkg::BURST_INCR, axi_slave_pkg::id_t'(t + 8));
    end
    gaps_on = 1'b0;

    // AW and AR rise together, write has priority
    fork
      write_burst(10'h300, 8'd1, axi_slave_pkg::BURST_INCR, 4'ha, 1'b0, 1'b0);
      read_burst(10'h300, 8'd1, axi_slave_pkg::BURST_INCR, 4'hb);
    join
    repeat (2) @(negedge aclk);
    compare_value("AR after B", ar_cyc > b_cyc, 1'b1);
    compare_value("read burst open", rd_open, 1'b0);

    total = mismatch_cnt + timeout_cnt + dut.u_asserts.assert_fails;
    $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatch_cnt, timeout_cnt, dut.u_asserts.assert_fails);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* sim.f */
source/axi_slave_pkg.sv
source/axi_txn_arbiter.sv
source/axi_addr_gen.sv
source/axi_write_ctrl.sv
source/axi_read_ctrl.sv
source/beat_memory.sv
source/axi_burst_slave.sv
bench/axi_burst_slave_asserts.sv
bench/tb_axi_burst_slave.sv

/* source/axi_addr_gen.sv */
`timescale 1ns/10ps

module axi_addr_gen (
  input  logic                  i_s_axi_aclk,
  input  logic                  i_s_axi_aresetn,
  input  logic                  i_start,
  input  logic                  i_step,
  input  axi_slave_pkg::addr_t  i_addr,
  input  axi_slave_pkg::len_t   i_len,
  input  axi_slave_pkg::burst_t i_burst,
  output axi_slave_pkg::addr_t  o_addr,
  output axi_slave_pkg::addr_t  o_next_addr,
  output logic                  o_last
);

  axi_slave_pkg::addr_t  addr_q;
  axi_slave_pkg::len_t   len_q;
  axi_slave_pkg::burst_t burst_q;
  axi_slave_pkg::len_t   cnt_q;
  axi_slave_pkg::addr_t  incr_addr;
  axi_slave_pkg::addr_t  wrap_mask;
  axi_slave_pkg::addr_t  wrap_addr;

  // Aligned to the beat, plus one beat
  assign incr_addr = {addr_q[axi_slave_pkg::ADDR_W-1:axi_slave_pkg::ADDR_LSB] + 1'b1,
                      {axi_slave_pkg::ADDR_LSB{1'b0}}};

  // Legal wrap lengths are 2, 4, 8 or 16 beats, so (len+1)*8-1 is len with low ones
  assign wrap_mask = axi_slave_pkg::addr_t'({len_q, {axi_slave_pkg::ADDR_LSB{1'b1}}});

  // Upper bits stay, offset inside the block rolls over
  assign wrap_addr = (addr_q & ~wrap_mask) | (incr_addr & wrap_mask);

  always_comb begin
    case (burst_q)
      axi_slave_pkg::BURST_FIXED: o_next_addr = addr_q;
      axi_slave_pkg::BURST_WRAP:  o_next_addr = wrap_addr;
      axi_slave_pkg::BURST_INCR,
      axi_slave_pkg::BURST_RSVD:  o_next_addr = incr_addr;
    endcase
  end

  always_ff @(posedge i_s_axi_aclk) begin
    if (!i_s_axi_aresetn) begin
      len_q   <= '0;
      burst_q <= axi_slave_pkg::BURST_INCR;
      cnt_q   <= '0;
    end else if (i_start) begin
      len_q   <= i_len;
      burst_q <= i_burst;
      cnt_q   <= '0;
    end else if (i_step) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge i_s_axi_aclk) begin
    if (i_start) begin
      addr_q <= i_addr;
    end else if (i_step) begin
      addr_q <= o_next_addr;
    end
  end

  assign o_addr = addr_q;
  assign o_last = (cnt_q == len_q);

endmodule

/* source/axi_burst_slave.sv */
`timescale 1ns/10ps

module axi_burst_slave (
  input  logic                  i_s_axi_aclk,
  input  logic                  i_s_axi_aresetn,
  input  axi_slave_pkg::addr_t  i_s_axi_awaddr,
  input  axi_slave_pkg::len_t   i_s_axi_awlen,
  input  axi_slave_pkg::burst_t i_s_axi_awburst,
  input  axi_slave_pkg::id_t    i_s_axi_awid,
  input  logic                  i_s_axi_awvalid,
  output logic                  o_s_axi_awready,
  input  axi_slave_pkg::data_t  i_s_axi_wdata,
  input  axi_slave_pkg::strb_t  i_s_axi_wstrb,
  input  logic                  i_s_axi_wlast,
  input  logic                  i_s_axi_wvalid,
  output logic                  o_s_axi_wready,
  input  logic                  i_s_axi_bready,
  output logic                  o_s_axi_bvalid,
  output axi_slave_pkg::id_t    o_s_axi_bid,
  output logic [1:0]            o_s_axi_bresp,
  input  axi_slave_pkg::addr_t  i_s_axi_araddr,
  input  axi_slave_pkg::len_t   i_s_axi_arlen,
  input  axi_slave_pkg::burst_t i_s_axi_arburst,
  input  axi_slave_pkg::id_t    i_s_axi_arid,
  input  logic                  i_s_axi_arvalid,
  output logic                  o_s_axi_arready,
  input  logic                  i_s_axi_rready,
  output logic                  o_s_axi_rvalid,
  output axi_slave_pkg::data_t  o_s_axi_rdata,
  output axi_slave_pkg::id_t    o_s_axi_rid,
  output logic [1:0]            o_s_axi_rresp,
  output logic                  o_s_axi_rlast
);

  logic                      wr_grant;
  logic                      rd_grant;
  logic                      wr_done;
  logic                      rd_done;
  logic                      wr_start;
  logic                      wr_step;
  logic                      rd_start;
  logic                      rd_step;
  logic                      rd_last;
  logic                      mem_we;
  logic                      mem_re;
  axi_slave_pkg::addr_t      wr_addr;
  axi_slave_pkg::addr_t      rd_addr;
  axi_slave_pkg::addr_t      rd_next_addr;
  axi_slave_pkg::word_addr_t mem_raddr;

  axi_txn_arbiter u_arbiter (
    .i_s_axi_aclk   (i_s_axi_aclk),
    .i_s_axi_aresetn(i_s_axi_aresetn),
    .i_awvalid      (i_s_axi_awvalid),
    .i_arvalid      (i_s_axi_arvalid),
    .i_wr_done      (wr_done),
    .i_rd_done      (rd_done),
    .o_wr_grant     (wr_grant),
    .o_rd_grant     (rd_grant)
  );

  // Write beats use only the current address
  axi_addr_gen u_wr_addr (
    .i_s_axi_aclk   (i_s_axi_aclk),
    .i_s_axi_aresetn(i_s_axi_aresetn),
    .i_start        (wr_start),
    .i_step         (wr_step),
    .i_addr         (i_s_axi_awaddr),
    .i_len          (i_s_axi_awlen),
    .i_burst        (i_s_axi_awburst),
    .o_addr         (wr_addr),
    .o_next_addr    (),
    .o_last         ()
  );

  axi_addr_gen u_rd_addr (
    .i_s_axi_aclk   (i_s_axi_aclk),
    .i_s_axi_aresetn(i_s_axi_aresetn),
    .i_start        (rd_start),
    .i_step         (rd_step),
    .i_addr         (i_s_axi_araddr),
    .i_len          (i_s_axi_arlen),
    .i_burst        (i_s_axi_arburst),
    .o_addr         (rd_addr),
    .o_next_addr    (rd_next_addr),
    .o_last         (rd_last)
  );

  axi_write_ctrl u_write_ctrl (
    .i_s_axi_aclk   (i_s_axi_aclk),
    .i_s_axi_aresetn(i_s_axi_aresetn),
    .i_grant        (wr_grant),
    .i_awvalid      (i_s_axi_awvalid),
    .i_wvalid       (i_s_axi_wvalid),
    .i_wlast        (i_s_axi_wlast),
    .i_bready       (i_s_axi_bready),
    .i_awid         (i_s_axi_awid),
    .o_awready      (o_s_axi_awready),
    .o_wready       (o_s_axi_wready),
    .o_bvalid       (o_s_axi_bvalid),
    .o_start        (wr_start),
    .o_step         (wr_step),
    .o_mem_we       (mem_we),
    .o_done         (wr_done),
    .o_bid          (o_s_axi_bid),
    .o_bresp        (o_s_axi_bresp)
  );

  axi_read_ctrl u_read_ctrl (
    .i_s_axi_aclk   (i_s_axi_aclk),
    .i_s_axi_aresetn(i_s_axi_aresetn),
    .i_grant        (rd_grant),
    .i_arvalid      (i_s_axi_arvalid),
    .i_rready       (i_s_axi_rready),
    .i_last         (rd_last),
    .i_arid         (i_s_axi_arid),
    .i_addr         (rd_addr),
    .i_next_addr    (rd_next_addr),
    .o_arready      (o_s_axi_arready),
    .o_rvalid       (o_s_axi_rvalid),
    .o_rlast        (o_s_axi_rlast),
    .o_start        (rd_start),
    .o_step         (rd_step),
    .o_mem_re       (mem_re),
    .o_done         (rd_done),
    .o_mem_addr     (mem_raddr),
    .o_rid          (o_s_axi_rid),
    .o_rresp        (o_s_axi_rresp)
  );

  beat_memory u_mem (
    .i_s_axi_aclk(i_s_axi_aclk),
    .i_we        (mem_we),
    .i_re        (mem_re),
    .i_waddr     (wr_addr[axi_slave_pkg::ADDR_W-1:axi_slave_pkg::ADDR_LSB]),
    .i_raddr     (mem_raddr),
    .i_wdata     (i_s_axi_wdata),
    .i_wstrb     (i_s_axi_wstrb),
    .o_rdata     (o_s_axi_rdata)
  );

endmodule

/* source/axi_read_ctrl.sv */
`timescale 1ns/10ps

module axi_read_ctrl (
  input  logic                      i_s_axi_aclk,
  input  logic                      i_s_axi_aresetn,
  input  logic                      i_grant,
  input  logic                      i_arvalid,
  input  logic                      i_rready,
  input  logic                      i_last,
  input  axi_slave_pkg::id_t        i_arid,
  input  axi_slave_pkg::addr_t      i_addr,
  input  axi_slave_pkg::addr_t      i_next_addr,
  output logic                      o_arready,
  output logic                      o_rvalid,
  output logic                      o_rlast,
  output logic                      o_start,
  output logic                      o_step,
  output logic                      o_mem_re,
  output logic                      o_done,
  output axi_slave_pkg::word_addr_t o_mem_addr,
  output axi_slave_pkg::id_t        o_rid,
  output logic [1:0]                o_rresp
);

  axi_slave_pkg::rd_state_t state;
  logic                     ar_hs;
  logic                     r_hs;

  assign ar_hs = o_arready & i_arvalid;
  assign r_hs  = o_rvalid & i_rready;

  assign o_start = ar_hs;
  assign o_step  = r_hs;
  assign o_done  = r_hs & i_last;

  // Generator sits on the beat being presented, so its last flag marks RLAST
  assign o_rlast = o_rvalid & i_last;

  assign o_rresp = 2'b00;

  // Start word on entry to RD_DATA, then the following word on each handshake
  always_comb begin
    o_mem_re   = 1'b0;
    o_mem_addr = i_addr[axi_slave_pkg::ADDR_W-1:axi_slave_pkg::ADDR_LSB];
    if (state == axi_slave_pkg::RD_DATA) begin
      if (!o_rvalid) begin
        o_mem_re = 1'b1;
      end else if (r_hs && !i_last) begin
        o_mem_re   = 1'b1;
        o_mem_addr = i_next_addr[axi_slave_pkg::ADDR_W-1:axi_slave_pkg::ADDR_LSB];
      end
    end
  end

  always_ff @(posedge i_s_axi_aclk) begin
    if (!i_s_axi_aresetn) begin
      state     <= axi_slave_pkg::RD_IDLE;
      o_arready <= 1'b0;
      o_rvalid  <= 1'b0;
    end else begin
      case (state)
        axi_slave_pkg::RD_IDLE: begin
          if (i_grant) begin
            o_arready <= 1'b1;
            state     <= axi_slave_pkg::RD_ADDR;
          end
        end
        axi_slave_pkg::RD_ADDR: begin
          if (ar_hs) begin
            o_arready <= 1'b0;
            state     <= axi_slave_pkg::RD_DATA;
          end
        end
        axi_slave_pkg::RD_DATA: begin
          // RVALID rises with the first memory word and holds while RREADY is low
          if (!o_rvalid) begin
            o_rvalid <= 1'b1;
          end else if (o_done) begin
            o_rvalid <= 1'b0;
            state    <= axi_slave_pkg::RD_IDLE;
          end
        end
        default: state <= axi_slave_pkg::RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_s_axi_aclk) begin
    if (ar_hs) begin
      o_rid <= i_arid;
    end
  end

endmodule

/* source/axi_slave_pkg.sv */
package axi_slave_pkg;

  // Bus and memory geometry
  localparam int ADDR_W    = 10;
  localparam int DATA_W    = 64;
  localparam int STRB_W    = 8;
  localparam int ID_W      = 4;
  localparam int ADDR_LSB  = 3;
  localparam int MEM_WORDS = 128;
  localparam int WORD_AW   = 7;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [STRB_W-1:0]  strb_t;
  typedef logic [ID_W-1:0]    id_t;
  typedef logic [7:0]         len_t;
  typedef logic [WORD_AW-1:0] word_addr_t;

  // AxBURST encodings
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10,
    BURST_RSVD  = 2'b11
  } burst_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR,
    WR_DATA,
    WR_RESP
  } wr_state_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_WRITE,
    ARB_READ
  } arb_state_t;

endpackage

/* source/axi_txn_arbiter.sv */
`timescale 1ns/10ps

module axi_txn_arbiter (
  input  logic i_s_axi_aclk,
  input  logic i_s_axi_aresetn,
  input  logic i_awvalid,
  input  logic i_arvalid,
  input  logic i_wr_done,
  input  logic i_rd_done,
  output logic o_wr_grant,
  output logic o_rd_grant
);

  axi_slave_pkg::arb_state_t state;

  always_ff @(posedge i_s_axi_aclk) begin
    if (!i_s_axi_aresetn) begin
      state      <= axi_slave_pkg::ARB_IDLE;
      o_wr_grant <= 1'b0;
      o_rd_grant <= 1'b0;
    end else begin
      // Grants are single-cycle pulses
      o_wr_grant <= 1'b0;
      o_rd_grant <= 1'b0;
      case (state)
        axi_slave_pkg::ARB_IDLE: begin
          // Write side wins a tie
          if (i_awvalid) begin
            state      <= axi_slave_pkg::ARB_WRITE;
            o_wr_grant <= 1'b1;
          end else if (i_arvalid) begin
            state      <= axi_slave_pkg::ARB_READ;
            o_rd_grant <= 1'b1;
          end
        end
        axi_slave_pkg::ARB_WRITE: begin
          if (i_wr_done) begin
            state <= axi_slave_pkg::ARB_IDLE;
          end
        end
        axi_slave_pkg::ARB_READ: begin
          if (i_rd_done) begin
            state <= axi_slave_pkg::ARB_IDLE;
          end
        end
        default: state <= axi_slave_pkg::ARB_IDLE;
      endcase
    end
  end

endmodule

/* source/axi_write_ctrl.sv */
`timescale 1ns/10ps

module axi_write_ctrl (
  input  logic               i_s_axi_aclk,
  input  logic               i_s_axi_aresetn,
  input  logic               i_grant,
  input  logic               i_awvalid,
  input  logic               i_wvalid,
  input  logic               i_wlast,
  input  logic               i_bready,
  input  axi_slave_pkg::id_t i_awid,
  output logic               o_awready,
  output logic               o_wready,
  output logic               o_bvalid,
  output logic               o_start,
  output logic               o_step,
  output logic               o_mem_we,
  output logic               o_done,
  output axi_slave_pkg::id_t o_bid,
  output logic [1:0]         o_bresp
);

  axi_slave_pkg::wr_state_t state;
  logic                     aw_hs;
  logic                     w_hs;

  assign aw_hs = o_awready & i_awvalid;
  assign w_hs  = o_wready & i_wvalid;

  // Address generator loads on AW, advances on every accepted beat
  assign o_start  = aw_hs;
  assign o_step   = w_hs;
  assign o_mem_we = w_hs;
  assign o_done   = o_bvalid & i_bready;

  // Always OKAY
  assign o_bresp = 2'b00;

  always_ff @(posedge i_s_axi_aclk) begin
    if (!i_s_axi_aresetn) begin
      state     <= axi_slave_pkg::WR_IDLE;
      o_awready <= 1'b0;
      o_wready  <= 1'b0;
      o_bvalid  <= 1'b0;
    end else begin
      case (state)
        axi_slave_pkg::WR_IDLE: begin
          if (i_grant) begin
            o_awready <= 1'b1;
            state     <= axi_slave_pkg::WR_ADDR;
          end
        end
        axi_slave_pkg::WR_ADDR: begin
          if (aw_hs) begin
            o_awready <= 1'b0;
            o_wready  <= 1'b1;
            state     <= axi_slave_pkg::WR_DATA;
          end
        end
        axi_slave_pkg::WR_DATA: begin
          if (w_hs && i_wlast) begin
            o_wready <= 1'b0;
            o_bvalid <= 1'b1;
            state    <= axi_slave_pkg::WR_RESP;
          end
        end
        axi_slave_pkg::WR_RESP: begin
          if (o_done) begin
            o_bvalid <= 1'b0;
            state    <= axi_slave_pkg::WR_IDLE;
          end
        end
        default: state <= axi_slave_pkg::WR_IDLE;
      endcase
    end
  end

  // ID echoed on B
  always_ff @(posedge i_s_axi_aclk) begin
    if (aw_hs) begin
      o_bid <= i_awid;
    end
  end

endmodule

/* source/beat_memory.sv */
`timescale 1ns/10ps

module beat_memory (
  input  logic                      i_s_axi_aclk,
  input  logic                      i_we,
  input  logic                      i_re,
  input  axi_slave_pkg::word_addr_t i_waddr,
  input  axi_slave_pkg::word_addr_t i_raddr,
  input  axi_slave_pkg::data_t      i_wdata,
  input  axi_slave_pkg::strb_t      i_wstrb,
  output axi_slave_pkg::data_t      o_rdata
);

  axi_slave_pkg::data_t mem [0:axi_slave_pkg::MEM_WORDS-1];

  // Byte lanes written only where the strobe is set
  always_ff @(posedge i_s_axi_aclk) begin
    if (i_we) begin
      for (int b = 0; b < axi_slave_pkg::STRB_W; b++) begin
        if (i_wstrb[b]) begin
          mem[i_waddr][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  // Output register holds its word until the next read
  always_ff @(posedge i_s_axi_aclk) begin
    if (i_re) begin
      o_rdata <= mem[i_raddr];
    end
  end

endmodule
